//--- hdl/cpuPkg.sv
package cpuPkg;

    localparam int DataWidth = 16;
    localparam int RegCount = 16;
    localparam int RegAddrWidth = $clog2(RegCount);

    typedef logic [DataWidth-1:0] dataT;
    typedef logic [RegAddrWidth-1:0] regAddrT;

    typedef enum logic [3:0] {
        OpNop   = 4'd0,
        OpAdd   = 4'd1,
        OpSub   = 4'd2,
        OpAnd   = 4'd3,
        OpOr    = 4'd4,
        OpXor   = 4'd5,
        OpShl   = 4'd6,
        OpShr   = 4'd7,
        OpLi    = 4'd8,
        OpLui   = 4'd9,
        OpAddi  = 4'd10,
        OpBeqz  = 4'd11,
        OpBnez  = 4'd12,
        OpJal   = 4'd13,
        OpSpare = 4'd14,
        OpHalt  = 4'd15
    } opcodeT;

    // imm8 overlays the ra and rb fields
    typedef struct packed {
        opcodeT  opcode;
        regAddrT rd;
        regAddrT ra;
        regAddrT rb;
    } instrT;

    function automatic dataT signExtImm8(instrT instr);
        return {{(DataWidth - 8){instr.ra[RegAddrWidth-1]}}, instr.ra, instr.rb};
    endfunction

    // Instructions that stop fetch until they resolve in execute
    function automatic logic isControl(opcodeT op);
        return op inside {OpBeqz, OpBnez, OpJal, OpHalt};
    endfunction

    function automatic logic writesRd(opcodeT op);
        return op inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpShl, OpShr,
                          OpLi, OpLui, OpAddi, OpJal};
    endfunction

endpackage

//--- hdl/issueIf.sv
interface issueIf;
    import cpuPkg::*;

    logic    valid;
    opcodeT  opcode;
    dataT    dataA;
    dataT    dataB;
    dataT    imm;
    regAddrT rd;
    logic    writeEn;
    // Own PC of the instruction, used for links and branch targets
    dataT    pc;

    modport producer (
        output valid, opcode, dataA, dataB, imm, rd, writeEn, pc
    );

    modport consumer (
        input valid, opcode, dataA, dataB, imm, rd, writeEn, pc
    );

endinterface

//--- hdl/fetchUnit.sv
module fetchUnit #(
    parameter int InstMemDepth = 1024,
    localparam int FlashAddrWidth = (InstMemDepth > 1) ? $clog2(InstMemDepth) : 1
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      runEn,
    input  logic                      flashEn,
    input  logic [FlashAddrWidth-1:0] flashAddr,
    input  cpuPkg::dataT              flashData,
    input  logic                      holdFetch,
    input  logic                      redirectEn,
    input  cpuPkg::dataT              redirectPc,
    output logic                      fetchValid,
    output cpuPkg::dataT              fetchInstr,
    output cpuPkg::dataT              fetchPc
);
    import cpuPkg::*;

    dataT                instMem [InstMemDepth];
    dataT                pc;
    logic [FlashAddrWidth-1:0] memAddr;
    logic                fetchEn;

    // A fetch counts only while running and not held by decode
    assign fetchEn = runEn && !holdFetch;

    // PC wraps at the memory depth
    assign memAddr = pc[FlashAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (flashEn) begin
            instMem[flashAddr] <= flashData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (redirectEn) begin
            pc <= redirectPc;
        end else if (fetchEn) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= fetchEn;
        end
    end

    // Word and PC are captured every cycle, the valid flag qualifies them
    always_ff @(posedge clk) begin
        fetchInstr <= instMem[memAddr];
        fetchPc    <= pc;
    end

    // Flashing is only legal while the core is stopped
    assert property (@(posedge clk) disable iff (!rstN)
        !(flashEn && runEn))
        else $error("fetchUnit: flashEn and runEn high together");

endmodule

//--- hdl/registerFile.sv
module registerFile (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::regAddrT readAddrA,
    input  cpuPkg::regAddrT readAddrB,
    input  logic            writeEn,
    input  cpuPkg::regAddrT writeAddr,
    input  cpuPkg::dataT    writeData,
    output cpuPkg::dataT    readDataA,
    output cpuPkg::dataT    readDataB
);
    import cpuPkg::*;

    dataT regs [RegCount];

    // Write-through read, the only forwarding path in the core
    function automatic dataT readPort(regAddrT addr);
        if (writeEn && writeAddr == addr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

endmodule

//--- hdl/decodeUnit.sv
module decodeUnit (
    input  logic            clk,
    input  logic            rstN,
    input  logic            fetchValid,
    input  cpuPkg::dataT    fetchInstr,
    input  cpuPkg::dataT    fetchPc,
    input  cpuPkg::dataT    readDataA,
    input  cpuPkg::dataT    readDataB,
    output cpuPkg::regAddrT readAddrA,
    output cpuPkg::regAddrT readAddrB,
    output logic            holdFetch,
    issueIf.producer        issue
);
    import cpuPkg::*;

    instrT  instr;
    opcodeT opcode;
    logic   rdAsSourceA;
    dataT   imm;
    logic   decodeCtrl;
    logic   issuedCtrl;
    logic   haltSeen;

    assign instr  = instrT'(fetchInstr);
    assign opcode = instr.opcode;

    // LUI, ADDI and the branches read their own rd through port A
    assign rdAsSourceA = opcode inside {OpLui, OpAddi, OpBeqz, OpBnez};

    assign readAddrA = rdAsSourceA ? instr.rd : instr.ra;
    assign readAddrB = instr.rb;

    // Immediate selection
    always_comb begin
        if (opcode == OpLui) begin
            // Byte goes pre-shifted into the upper half
            imm = {instr.ra, instr.rb, 8'h00};
        end else begin
            imm = signExtImm8(instr);
        end
    end

    // Fetch stalls
    assign decodeCtrl = fetchValid && isControl(opcode);
    assign issuedCtrl = issue.valid && isControl(issue.opcode);
    assign holdFetch  = decodeCtrl || issuedCtrl || haltSeen;

    // Sticky once a HALT leaves decode
    always_ff @(posedge clk) begin
        if (!rstN) begin
            haltSeen <= 1'b0;
        end else if (fetchValid && opcode == OpHalt) begin
            haltSeen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= fetchValid;
        end
    end

    // Payload of the issue register
    always_ff @(posedge clk) begin
        issue.opcode  <= opcode;
        issue.dataA   <= readDataA;
        issue.dataB   <= readDataB;
        issue.imm     <= imm;
        issue.rd      <= instr.rd;
        issue.writeEn <= writesRd(opcode);
        issue.pc      <= fetchPc;
    end

    // haltSeen rises together with the issued HALT, so from the cycle
    // after it nothing valid may reach execute again
    assert property (@(posedge clk) disable iff (!rstN)
        haltSeen |=> !issue.valid)
        else $error("decodeUnit: valid issue after HALT");

endmodule

//--- hdl/executeUnit.sv
module executeUnit (
    input  logic            clk,
    input  logic            rstN,
    issueIf.consumer        issue,
    output logic            wbEn,
    output cpuPkg::regAddrT wbAddr,
    output cpuPkg::dataT    wbData,
    output logic            redirectEn,
    output cpuPkg::dataT    redirectPc,
    output logic            halted
);
    import cpuPkg::*;

    dataT arithResult;
    dataT shiftResult;
    dataT linkPc;
    dataT branchTarget;
    logic isBranch;
    logic isJal;
    logic taken;

    // Arithmetic and logic group
    always_comb begin
        case (issue.opcode)
            OpSub:   arithResult = issue.dataA - issue.dataB;
            OpAnd:   arithResult = issue.dataA & issue.dataB;
            OpOr:    arithResult = issue.dataA | issue.dataB;
            OpXor:   arithResult = issue.dataA ^ issue.dataB;
            default: arithResult = issue.dataA + issue.dataB;
        endcase
    end

    // Shift group, amount from the low four bits of rb
    always_comb begin
        if (issue.opcode == OpShl) begin
            shiftResult = issue.dataA << issue.dataB[3:0];
        end else begin
            shiftResult = issue.dataA >> issue.dataB[3:0];
        end
    end

    assign linkPc       = issue.pc + 1'b1;
    assign branchTarget = linkPc + issue.imm;

    always_comb begin
        case (issue.opcode)
            OpShl, OpShr: wbData = shiftResult;
            OpLi:         wbData = issue.imm;
            OpLui:        wbData = {issue.imm[DataWidth-1:8], issue.dataA[7:0]};
            OpAddi:       wbData = issue.dataA + issue.imm;
            OpJal:        wbData = linkPc;
            default:      wbData = arithResult;
        endcase
    end

    assign wbEn   = issue.valid && issue.writeEn;
    assign wbAddr = issue.rd;

    // Branch resolution, dataA holds rd here
    assign isBranch = issue.opcode inside {OpBeqz, OpBnez};
    assign isJal    = issue.opcode == OpJal;
    assign taken    = (issue.opcode == OpBeqz) ? (issue.dataA == '0) : (issue.dataA != '0);

    // Not-taken branches also redirect, to their fall-through PC
    assign redirectEn = issue.valid && (isBranch || isJal);

    always_comb begin
        if (isJal) begin
            redirectPc = issue.dataA;
        end else if (taken) begin
            redirectPc = branchTarget;
        end else begin
            redirectPc = linkPc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (issue.valid && issue.opcode == OpHalt) begin
            halted <= 1'b1;
        end
    end

    // Decode holds fetch behind a control instruction, so a redirect is
    // always followed by a bubble
    assert property (@(posedge clk) disable iff (!rstN)
        redirectEn |=> !issue.valid)
        else $error("executeUnit: redirect not followed by a bubble");

endmodule

//--- hdl/cpuCore.sv
module cpuCore #(
    parameter int InstMemDepth = 1024,
    localparam int FlashAddrWidth = (InstMemDepth > 1) ? $clog2(InstMemDepth) : 1
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      runEn,
    input  logic                      flashEn,
    input  logic [FlashAddrWidth-1:0] flashAddr,
    input  cpuPkg::dataT              flashData,
    output logic                      halted,
    output logic                      regWriteEn,
    output cpuPkg::regAddrT           regWriteAddr,
    output cpuPkg::dataT              regWriteData
);
    import cpuPkg::*;

    issueIf issueBus ();

    logic    holdFetch;
    logic    redirectEn;
    dataT    redirectPc;
    logic    fetchValid;
    dataT    fetchInstr;
    dataT    fetchPc;
    regAddrT readAddrA;
    regAddrT readAddrB;
    dataT    readDataA;
    dataT    readDataB;

    fetchUnit #(
        .InstMemDepth(InstMemDepth)
    ) fetch (
        .clk       (clk),
        .rstN      (rstN),
        .runEn     (runEn),
        .flashEn   (flashEn),
        .flashAddr (flashAddr),
        .flashData (flashData),
        .holdFetch (holdFetch),
        .redirectEn(redirectEn),
        .redirectPc(redirectPc),
        .fetchValid(fetchValid),
        .fetchInstr(fetchInstr),
        .fetchPc   (fetchPc)
    );

    // Writeback goes straight to the register file and the test outputs
    registerFile regFile (
        .clk      (clk),
        .rstN     (rstN),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .writeEn  (regWriteEn),
        .writeAddr(regWriteAddr),
        .writeData(regWriteData),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    decodeUnit decode (
        .clk       (clk),
        .rstN      (rstN),
        .fetchValid(fetchValid),
        .fetchInstr(fetchInstr),
        .fetchPc   (fetchPc),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .holdFetch (holdFetch),
        .issue     (issueBus)
    );

    executeUnit execute (
        .clk       (clk),
        .rstN      (rstN),
        .issue     (issueBus),
        .wbEn      (regWriteEn),
        .wbAddr    (regWriteAddr),
        .wbData    (regWriteData),
        .redirectEn(redirectEn),
        .redirectPc(redirectPc),
        .halted    (halted)
    );

endmodule

//--- dv/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

dataT    prog [128];
int      progLen;
regAddrT expAddr [$];
dataT    expData [$];
bit      modelHalted;

// Mostly r0..r3 so that neighbouring instructions depend on each other
function automatic regAddrT pickReg();
    if ($urandom_range(3) != 0) begin
        return regAddrT'($urandom_range(3));
    end
    return regAddrT'($urandom_range(15));
endfunction

function automatic dataT encode(opcodeT op, regAddrT rd, logic [7:0] low);
    return {op, rd, low};
endfunction

function automatic void genProgram();
    int      i;
    int      roll;
    int      span;
    int      tgt;
    regAddrT link;
    progLen = 40 + $urandom_range(40);
    i = 0;
    while (i < progLen - 1) begin
        roll = $urandom_range(99);
        // Words left between this one and the closing HALT
        span = progLen - 2 - i;
        if (roll < 12) begin
            prog[i] = encode((roll < 6) ? OpBeqz : OpBnez, pickReg(),
                             8'($urandom_range((span < 12) ? span : 12)));
            i++;
        end else if (roll < 18 && span > 0) begin
            // LI of a forward target, then JAL through that register
            link = pickReg();
            prog[i] = encode(OpLi, link,
                             8'(i + 2 + $urandom_range((span < 11) ? span - 1 : 10)));
            prog[i + 1] = encode(OpJal, pickReg(), {link, 4'h0});
            i += 2;
        end else begin
            prog[i] = encode((roll > 95) ? OpSpare : opcodeT'(roll % 11), pickReg(),
                             8'($urandom_range(255)));
            i++;
        end
    end
    prog[progLen - 1] = encode(OpHalt, 4'h0, 8'h00);
    // Jumps land on the LI of a pair and never on its JAL
    for (int k = 0; k < progLen - 1; k++) begin
        if (prog[k][15:12] inside {OpBeqz, OpBnez}) begin
            tgt = k + 1 + prog[k][7:0];
            if (prog[tgt][15:12] == OpJal) begin
                prog[k][7:0] = prog[k][7:0] - 8'd1;
            end
        end else if (prog[k][15:12] == OpLi && prog[k + 1][15:12] == OpJal) begin
            tgt = prog[k][7:0];
            if (prog[tgt][15:12] == OpJal) begin
                prog[k][7:0] = prog[k][7:0] - 8'd1;
            end
        end
    end
endfunction

// Instruction-level run of the program, records every register write in order
function automatic void predictWrites();
    dataT   regs [16];
    dataT   word;
    dataT   imm;
    dataT   a;
    dataT   b;
    dataT   rdVal;
    dataT   result;
    opcodeT op;
    int     pc;
    int     nextPc;
    bit     wr;
    expAddr.delete();
    expData.delete();
    modelHalted = 1'b0;
    foreach (regs[r]) begin
        regs[r] = '0;
    end
    pc = 0;
    for (int step = 0; step < 1000 && pc < progLen; step++) begin
        word   = prog[pc];
        op     = opcodeT'(word[15:12]);
        a      = regs[word[7:4]];
        b      = regs[word[3:0]];
        rdVal  = regs[word[11:8]];
        imm    = {{8{word[7]}}, word[7:0]};
        wr     = 1'b1;
        nextPc = pc + 1;
        case (op)
            OpAdd:  result = a + b;
            OpSub:  result = a - b;
            OpAnd:  result = a & b;
            OpOr:   result = a | b;
            OpXor:  result = a ^ b;
            OpShl:  result = a << b[3:0];
            OpShr:  result = a >> b[3:0];
            OpLi:   result = imm;
            OpLui:  result = {word[7:0], rdVal[7:0]};
            OpAddi: result = rdVal + imm;
            OpJal: begin
                result = dataT'(pc + 1);
                nextPc = a;
            end
            OpBeqz, OpBnez: begin
                wr = 1'b0;
                if ((rdVal == '0) == (op == OpBeqz)) begin
                    nextPc = pc + 1 + $signed(word[7:0]);
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr) begin
            regs[word[11:8]] = result;
            expAddr.push_back(word[11:8]);
            expData.push_back(result);
        end
        if (op == OpHalt) begin
            modelHalted = 1'b1;
            break;
        end
        pc = nextPc;
    end
endfunction

`endif

//--- dv/cpuTb.sv
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpuPkg::*;

    localparam int InstMemDepth = 1024;
    localparam int FlashAddrWidth = $clog2(InstMemDepth);
    localparam int RunCount = 20;
    localparam int HaltTimeout = 2000;

    logic                      clk;
    logic                      rstN;
    logic                      runEn;
    logic                      flashEn;
    logic [FlashAddrWidth-1:0] flashAddr;
    dataT                      flashData;
    logic                      halted;
    logic                      regWriteEn;
    regAddrT                   regWriteAddr;
    dataT                      regWriteData;
    int                        errors;
    int                        checks;
    bit                        timedOut;

    `include "isaModel.svh"

    cpuCore #(.InstMemDepth(InstMemDepth)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Outputs come from registers, so 1 ns after the edge they hold this cycle's values
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkIdle();
        checks++;
        if (halted !== 1'b0) begin
            errors++;
            $display("FAIL halted: got 0x%h, expected 0x0", halted);
        end
        if (regWriteEn !== 1'b0) begin
            errors++;
            $display("FAIL regWriteEn: got 0x%h, expected 0x0", regWriteEn);
        end
    endtask

    task automatic checkWrite();
        regAddrT wantAddr;
        dataT    wantData;
        if (regWriteEn !== 1'b1) begin
            return;
        end
        checks++;
        if (expAddr.size() == 0) begin
            errors++;
            $display("Register write to r%0d after the predicted writes ended", regWriteAddr);
            return;
        end
        wantAddr = expAddr.pop_front();
        wantData = expData.pop_front();
        if (regWriteAddr !== wantAddr) begin
            errors++;
            $display("FAIL regWriteAddr: got 0x%h, expected 0x%h", regWriteAddr, wantAddr);
        end
        if (regWriteData !== wantData) begin
            errors++;
            $display("FAIL regWriteData: got 0x%h, expected 0x%h", regWriteData, wantData);
        end
    endtask

    task automatic resetAndFlash();
        rstN  = 1'b0;
        runEn = 1'b0;
        repeat (8) begin
            nextCycle();
            checkIdle();
        end
        rstN = 1'b1;
        for (int a = 0; a < progLen; a++) begin
            flashEn   = 1'b1;
            flashAddr = FlashAddrWidth'(a);
            flashData = prog[a];
            nextCycle();
            checkIdle();
        end
        flashEn = 1'b0;
    endtask

    task automatic runProgram(int run);
        int expCount;
        int pause;
        int cycles;
        expCount = expAddr.size();
        pause    = 0;
        cycles   = 0;
        runEn    = 1'b1;
        while (halted !== 1'b1) begin
            if (cycles == HaltTimeout) begin
                errors++;
                timedOut = 1'b1;
                $display("Run %0d: halted did not rise within %0d cycles", run, HaltTimeout);
                return;
            end
            nextCycle();
            cycles++;
            checkWrite();
            // Random stretches with the core stopped
            if (pause > 0) begin
                pause--;
            end else if ($urandom_range(15) == 0) begin
                pause = 1 + $urandom_range(5);
            end
            runEn = (pause == 0);
        end
        runEn = 1'b1;
        repeat (10) begin
            nextCycle();
            checkWrite();
            checks++;
            if (halted !== 1'b1) begin
                errors++;
                $display("FAIL halted: got 0x%h, expected 0x1", halted);
            end
        end
        if (expAddr.size() != 0) begin
            errors++;
            $display("FAIL write count: got 0x%h, expected 0x%h",
                     expCount - expAddr.size(), expCount);
        end
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        timedOut  = 1'b0;
        rstN      = 1'b0;
        runEn     = 1'b0;
        flashEn   = 1'b0;
        flashAddr = '0;
        flashData = '0;
        void'($urandom(32'he6f4));
        for (int run = 0; run < RunCount && !timedOut; run++) begin
            genProgram();
            predictWrites();
            if (!modelHalted) begin
                errors++;
                $display("Run %0d: reference model never reached HALT", run);
            end
            resetAndFlash();
            runProgram(run);
        end
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+dv
hdl/cpuPkg.sv
hdl/issueIf.sv
hdl/fetchUnit.sv
hdl/registerFile.sv
hdl/decodeUnit.sv
hdl/executeUnit.sv
hdl/cpuCore.sv
dv/cpuTb.sv
